/* hw/instr_cache.sv */
// direct-mapped, one word per line; the core must hold fetch_addr_i while fetch_wait_o is high
`default_nettype none
`timescale 1ns/1ps

module instr_cache import soc_mem_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // core fetch port
    input  logic [XLEN-1:0] fetch_addr_i,
    output logic            fetch_wait_o,
    output logic [XLEN-1:0] fetch_data_o,

    // refill towards the memory controller
    output logic            ic_valid_o,
    output logic [XLEN-1:0] ic_addr_o,
    input  logic            ic_ready_i,
    input  logic [XLEN-1:0] ic_rdata_i,

    // data write snoop
    input  logic            snoop_valid_i,
    input  logic [XLEN-1:0] snoop_addr_i
);

    // ============================================================
    // storage
    // ============================================================
    logic [IC_TAG_W-1:0] tag_q  [IC_LINES];
    logic [XLEN-1:0]     data_q [IC_LINES];
    logic [IC_LINES-1:0] valid_q;

    logic [IC_IDX_W-1:0] fetch_idx;
    logic [IC_TAG_W-1:0] fetch_tag;
    logic [IC_IDX_W-1:0] snoop_idx;
    logic [IC_TAG_W-1:0] snoop_tag;
    logic [IC_IDX_W-1:0] refill_idx;
    logic [IC_TAG_W-1:0] refill_tag;

    logic                hit;
    logic                snoop_hit;
    logic                refill_q;
    logic                refill_done;
    logic [XLEN-1:0]     refill_addr_q;

    // address split: tag | index | byte offset
    assign fetch_idx  = fetch_addr_i[IC_IDX_W+1:2];
    assign fetch_tag  = fetch_addr_i[XLEN-1:IC_IDX_W+2];
    assign snoop_idx  = snoop_addr_i[IC_IDX_W+1:2];
    assign snoop_tag  = snoop_addr_i[XLEN-1:IC_IDX_W+2];
    assign refill_idx = refill_addr_q[IC_IDX_W+1:2];
    assign refill_tag = refill_addr_q[XLEN-1:IC_IDX_W+2];

    // ============================================================
    // lookup
    // ============================================================
    assign hit          = valid_q[fetch_idx] & (tag_q[fetch_idx] == fetch_tag);
    assign fetch_wait_o = ~hit;
    assign fetch_data_o = data_q[fetch_idx];

    assign snoop_hit = snoop_valid_i & valid_q[snoop_idx] & (tag_q[snoop_idx] == snoop_tag);

    // ============================================================
    // refill
    // ============================================================
    assign refill_done = refill_q & ic_ready_i;
    assign ic_valid_o  = refill_q;
    assign ic_addr_o   = refill_addr_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            refill_q <= 1'b0;
        end else if (refill_done) begin
            refill_q <= 1'b0;
        end else if (!hit) begin
            refill_q <= 1'b1;
        end
    end

    // capture the missing word when the request goes out
    always_ff @(posedge clk_i) begin
        if (!refill_q && !hit) begin
            refill_addr_q <= {fetch_addr_i[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_done) begin
            tag_q[refill_idx]  <= refill_tag;
            data_q[refill_idx] <= ic_rdata_i;
        end
    end

    // refill is written last so it wins over a snoop on the same index
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            if (snoop_hit) begin
                valid_q[snoop_idx] <= 1'b0;
            end
            if (refill_done) begin
                valid_q[refill_idx] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/machine_timer.sv */
// 32-bit free-running timer, full-word access only; irq lags the compare by one cycle
`default_nettype none
`timescale 1ns/1ps

module machine_timer import soc_mem_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 tmr_sel_i,
    input  logic                 tmr_we_i,
    input  logic [TMR_OFS_W-1:0] tmr_addr_i,
    input  logic [XLEN-1:0]      tmr_wdata_i,
    output logic [XLEN-1:0]      tmr_rdata_o,

    output logic                 timer_irq_o
);

    logic [XLEN-1:0] count_q;
    logic [XLEN-1:0] cmp_q;
    logic            cnt_wr;
    logic            cmp_wr;

    assign cnt_wr = tmr_sel_i & tmr_we_i & (tmr_addr_i == TMR_CNT_OFS);
    assign cmp_wr = tmr_sel_i & tmr_we_i & (tmr_addr_i == TMR_CMP_OFS);

    // ============================================================
    // counter and compare
    // ============================================================
    // a software load takes priority over the increment
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (cnt_wr) begin
            count_q <= tmr_wdata_i;
        end else begin
            count_q <= count_q + XLEN'(1);
        end
    end

    // all ones keeps the irq quiet out of reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cmp_q <= '1;
        end else if (cmp_wr) begin
            cmp_q <= tmr_wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            timer_irq_o <= 1'b0;
        end else begin
            timer_irq_o <= (count_q >= cmp_q);
        end
    end

    // ============================================================
    // read mux
    // ============================================================
    always_comb begin
        tmr_rdata_o = '0;
        if (tmr_sel_i) begin
            if (tmr_addr_i == TMR_CNT_OFS) begin
                tmr_rdata_o = count_q;
            end else if (tmr_addr_i == TMR_CMP_OFS) begin
                tmr_rdata_o = cmp_q;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mem_ctrl.sv */
// data port decoder and two-master memory arbiter; timer writes ignore the byte mask
`default_nettype none
`timescale 1ns/1ps

module mem_ctrl import soc_mem_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // core data port
    input  logic                 data_sel_i,
    input  data_req_t            data_req_i,
    output logic                 data_stall_o,
    output logic [XLEN-1:0]      data_rdata_o,

    // instruction cache refill port
    input  logic                 ic_valid_i,
    input  logic [XLEN-1:0]      ic_addr_i,
    output logic                 ic_ready_o,
    output logic [XLEN-1:0]      ic_rdata_o,

    // write snoop towards the instruction cache
    output logic                 snoop_valid_o,
    output logic [XLEN-1:0]      snoop_addr_o,

    // machine timer
    output logic                 tmr_sel_o,
    output logic                 tmr_we_o,
    output logic [TMR_OFS_W-1:0] tmr_addr_o,
    output logic [XLEN-1:0]      tmr_wdata_o,
    input  logic [XLEN-1:0]      tmr_rdata_i,

    // external memory port
    output logic                 mem_valid_o,
    output mem_req_t             mem_req_o,
    input  logic                 mem_ready_i,
    input  mem_rsp_t             mem_rsp_i
);

    typedef enum logic [1:0] {
        IDLE,
        DATA_BUSY,
        FETCH_BUSY,
        DATA_DONE
    } arb_state_e;

    arb_state_e      state_q;
    arb_state_e      state_d;
    mem_req_t        req_q;
    logic [XLEN-1:0] rdata_q;

    logic            is_mem;
    logic            is_tmr;
    logic            data_mem_req;
    logic            xfer_done;

    // ============================================================
    // data address decode
    // ============================================================
    assign is_mem       = data_req_i.addr[MEM_SEL_BIT];
    assign is_tmr       = ~is_mem & data_req_i.addr[TMR_SEL_BIT];
    assign data_mem_req = data_sel_i & is_mem;

    assign tmr_sel_o   = data_sel_i & is_tmr;
    assign tmr_we_o    = data_req_i.we;
    assign tmr_addr_o  = data_req_i.addr[TMR_OFS_W-1:0];
    assign tmr_wdata_o = data_req_i.wdata;

    // only main memory can stall, and only until the done cycle
    assign data_stall_o = data_mem_req & (state_q != DATA_DONE);

    always_comb begin
        if (is_mem) begin
            data_rdata_o = rdata_q;
        end else if (is_tmr) begin
            data_rdata_o = tmr_rdata_i;
        end else begin
            // unmapped reads return zero
            data_rdata_o = '0;
        end
    end

    // ============================================================
    // arbiter
    // ============================================================
    assign xfer_done = mem_valid_o & mem_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // data has priority over fetch
                if (data_mem_req) begin
                    state_d = DATA_BUSY;
                end else if (ic_valid_i) begin
                    state_d = FETCH_BUSY;
                end
            end
            DATA_BUSY: begin
                if (mem_ready_i) begin
                    state_d = DATA_DONE;
                end
            end
            FETCH_BUSY: begin
                if (mem_ready_i) begin
                    state_d = IDLE;
                end
            end
            DATA_DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // granted request is held here until the transfer completes
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            if (data_mem_req) begin
                req_q.addr  <= {data_req_i.addr[XLEN-1:2], 2'b00};
                req_q.wdata <= data_req_i.wdata;
                req_q.wstrb <= data_req_i.we ? data_req_i.mask : '0;
            end else begin
                req_q.addr  <= ic_addr_i;
                req_q.wdata <= '0;
                req_q.wstrb <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == DATA_BUSY && mem_ready_i) begin
            rdata_q <= mem_rsp_i.rdata;
        end
    end

    assign mem_valid_o = (state_q == DATA_BUSY) || (state_q == FETCH_BUSY);
    assign mem_req_o   = req_q;

    assign ic_ready_o = (state_q == FETCH_BUSY) & mem_ready_i;
    assign ic_rdata_o = mem_rsp_i.rdata;

    // invalidate a cached copy of any word the data side writes
    assign snoop_valid_o = xfer_done & (state_q == DATA_BUSY) & (|req_q.wstrb);
    assign snoop_addr_o  = req_q.addr;

endmodule

`default_nettype wire

/* hw/mem_subsystem.sv */
// memory side of the core: icache + data decode + timer on one valid/ready port, no data cache
`default_nettype none
`timescale 1ns/1ps

module mem_subsystem import soc_mem_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // core instruction fetch
    input  logic [31:0]     fetch_addr_i,
    output logic            fetch_wait_o,
    output logic [XLEN-1:0] fetch_data_o,

    // core data access
    input  logic            data_sel_i,
    input  data_req_t       data_req_i,
    output logic            data_stall_o,
    output logic [XLEN-1:0] data_rdata_o,

    // external memory
    output logic            mem_valid_o,
    output mem_req_t        mem_req_o,
    input  logic            mem_ready_i,
    input  mem_rsp_t        mem_rsp_i,

    output logic            timer_irq_o
);

    // refill path
    logic                 ic_valid;
    logic [XLEN-1:0]      ic_addr;
    logic                 ic_ready;
    logic [XLEN-1:0]      ic_rdata;

    // snoop path
    logic                 snoop_valid;
    logic [XLEN-1:0]      snoop_addr;

    // timer register access
    logic                 tmr_sel;
    logic                 tmr_we;
    logic [TMR_OFS_W-1:0] tmr_addr;
    logic [XLEN-1:0]      tmr_wdata;
    logic [XLEN-1:0]      tmr_rdata;

    instr_cache i_instr_cache (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_wait_o  (fetch_wait_o),
        .fetch_data_o  (fetch_data_o),
        .ic_valid_o    (ic_valid),
        .ic_addr_o     (ic_addr),
        .ic_ready_i    (ic_ready),
        .ic_rdata_i    (ic_rdata),
        .snoop_valid_i (snoop_valid),
        .snoop_addr_i  (snoop_addr)
    );

    mem_ctrl i_mem_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .data_sel_i    (data_sel_i),
        .data_req_i    (data_req_i),
        .data_stall_o  (data_stall_o),
        .data_rdata_o  (data_rdata_o),
        .ic_valid_i    (ic_valid),
        .ic_addr_i     (ic_addr),
        .ic_ready_o    (ic_ready),
        .ic_rdata_o    (ic_rdata),
        .snoop_valid_o (snoop_valid),
        .snoop_addr_o  (snoop_addr),
        .tmr_sel_o     (tmr_sel),
        .tmr_we_o      (tmr_we),
        .tmr_addr_o    (tmr_addr),
        .tmr_wdata_o   (tmr_wdata),
        .tmr_rdata_i   (tmr_rdata),
        .mem_valid_o   (mem_valid_o),
        .mem_req_o     (mem_req_o),
        .mem_ready_i   (mem_ready_i),
        .mem_rsp_i     (mem_rsp_i)
    );

    machine_timer i_machine_timer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .tmr_sel_i   (tmr_sel),
        .tmr_we_i    (tmr_we),
        .tmr_addr_i  (tmr_addr),
        .tmr_wdata_i (tmr_wdata),
        .tmr_rdata_o (tmr_rdata),
        .timer_irq_o (timer_irq_o)
    );

endmodule

`default_nettype wire

/* hw/soc_mem_pkg.sv */
// widths, address map and bus structs shared by the memory side; addresses are byte addresses
`default_nettype none

package soc_mem_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int XLEN     = 32;
    localparam int IC_LINES = 16;
    localparam int IC_IDX_W = 4;
    // tag is what is left above the index and the byte offset
    localparam int IC_TAG_W = XLEN - IC_IDX_W - 2;

    // ============================================================
    // address map
    // ============================================================
    // bit 30 wins over bit 28 when both are set
    localparam int MEM_SEL_BIT = 30;
    localparam int TMR_SEL_BIT = 28;

    // timer registers are decoded on the low address byte only
    localparam int TMR_OFS_W = 8;
    localparam logic [TMR_OFS_W-1:0] TMR_CNT_OFS = 8'h00;
    localparam logic [TMR_OFS_W-1:0] TMR_CMP_OFS = 8'h04;

    // ============================================================
    // bus payloads
    // ============================================================
    // external memory request, nonzero wstrb means write
    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
        logic [XLEN/8-1:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        logic [XLEN-1:0] rdata;
    } mem_rsp_t;

    // core data port request
    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
        logic [XLEN/8-1:0] mask;
        logic              we;
    } data_req_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it; a failing check ends in $fatal and a nonzero exit
set -e
cd "$(dirname "$0")"
verilator --binary --timescale 1ns/1ps --top-module tb_mem_subsystem -f vlog.f -o sim_tb
./obj_dir/sim_tb

/* tb/tb_mem_model.sv */
// memory responder with 1024 words at addr[11:2], upper address bits ignored, 1 to 4 cycles to ready
`default_nettype none
`timescale 1ns/1ps

module tb_mem_model import soc_mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     mem_valid_i,
    input  mem_req_t mem_req_i,
    output logic     mem_ready_o,
    output mem_rsp_t mem_rsp_o
);

    localparam logic [31:0] SEED = 32'h5e74ce08;

    logic [31:0] mem [1024];
    // address of every completed transfer, in order
    logic [31:0] log_addr [256];
    int          xfer_cnt;

    logic [31:0] lfsr_q;
    logic [31:0] step1;
    logic [31:0] step2;
    logic [1:0]  wait_q;
    logic [9:0]  idx;
    logic [31:0] wmask;

    // galois form, one step per random bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    initial begin
        logic [31:0] s;
        logic [31:0] w;
        s = SEED;
        for (int i = 0; i < 1024; i++) begin
            w = '0;
            for (int b = 0; b < 32; b++) begin
                s = lfsr_step(s);
                w = {w[30:0], s[0]};
            end
            mem[10'(i)] <= w;
        end
    end

    assign step1           = lfsr_step(lfsr_q);
    assign step2           = lfsr_step(step1);
    assign idx             = mem_req_i.addr[11:2];
    assign mem_rsp_o.rdata = mem[idx];
    assign wmask           = {{8{mem_req_i.wstrb[3]}}, {8{mem_req_i.wstrb[2]}},
                              {8{mem_req_i.wstrb[1]}}, {8{mem_req_i.wstrb[0]}}};

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_ready_o <= 1'b0;
            wait_q      <= 2'd0;
            lfsr_q      <= SEED;
            xfer_cnt    <= 0;
        end else if (mem_valid_i && mem_ready_o) begin
            mem_ready_o             <= 1'b0;
            mem[idx]                <= (mem[idx] & ~wmask) | (mem_req_i.wdata & wmask);
            log_addr[xfer_cnt[7:0]] <= mem_req_i.addr;
            xfer_cnt                <= xfer_cnt + 1;
            // two fresh bits give the extra wait of the next request
            wait_q                  <= {step2[0], step1[0]};
            lfsr_q                  <= step2;
        end else if (mem_valid_i) begin
            if (wait_q == 2'd0) begin
                mem_ready_o <= 1'b1;
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_mem_subsystem.sv */
// row-table testbench for mem_subsystem; stops at the first mismatch, fetches park on 0x4000_0000
`default_nettype none
`timescale 1ns/1ps

module tb_mem_subsystem import soc_mem_pkg::*; ();

    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] PARK_ADDR    = 32'h4000_0000;

    typedef enum logic [2:0] {
        OP_FETCH, OP_LOAD, OP_STORE, OP_TWR, OP_TRD, OP_TCNT, OP_IRQ, OP_BOTH
    } op_e;

    // exp is the transfer count for memory rows and the read value for timer rows
    typedef struct {
        string       name;
        op_e         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
        logic [31:0] exp;
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] fetch_addr;
    logic        fetch_wait;
    logic [31:0] fetch_data;
    logic        data_sel;
    data_req_t   data_req;
    logic        data_stall;
    logic [31:0] data_rdata;
    logic        mem_valid;
    mem_req_t    mem_req;
    logic        mem_ready;
    mem_rsp_t    mem_rsp;
    logic        timer_irq;

    row_t        rows [$];
    logic [31:0] shadow [1024];

    always #50 clk = ~clk;

    mem_subsystem i_mem_subsystem (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .fetch_addr_i (fetch_addr),
        .fetch_wait_o (fetch_wait),
        .fetch_data_o (fetch_data),
        .data_sel_i   (data_sel),
        .data_req_i   (data_req),
        .data_stall_o (data_stall),
        .data_rdata_o (data_rdata),
        .mem_valid_o  (mem_valid),
        .mem_req_o    (mem_req),
        .mem_ready_i  (mem_ready),
        .mem_rsp_i    (mem_rsp),
        .timer_irq_o  (timer_irq)
    );

    tb_mem_model i_tb_mem_model (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .mem_valid_i (mem_valid),
        .mem_req_i   (mem_req),
        .mem_ready_o (mem_ready),
        .mem_rsp_o   (mem_rsp)
    );

    // ============================================================
    // checks
    // ============================================================
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s: expected %h/%h/%h, actual %h/%h/%h", name,
                exp.addr, exp.wdata, exp.wstrb, act.addr, act.wdata, act.wstrb));
        end
    endtask

    function automatic int watchdog_cycles();
        return rows.size() * 64 + 4 * RESET_CYCLES;
    endfunction

    function automatic logic [31:0] strobe_mask(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    // ============================================================
    // port drivers
    // ============================================================
    task automatic wait_fetch(input string name, input logic expect_hit, output logic [31:0] data);
        @(negedge clk);
        if (expect_hit) begin
            check_count({name, " wait"}, 0, int'(fetch_wait));
        end
        while (fetch_wait) begin
            @(negedge clk);
        end
        data = fetch_data;
        @(posedge clk);
        fetch_addr <= PARK_ADDR;
    endtask

    task automatic run_data(
        input  string       name,
        input  logic [31:0] addr,
        input  logic [31:0] wdata,
        input  logic [3:0]  mask,
        input  logic        we,
        input  logic        fetch_en,
        input  logic [31:0] faddr,
        output logic [31:0] rdata,
        output int          stalls
    );
        data_req_t req;
        mem_req_t  want_req;
        req.addr       = addr;
        req.wdata      = wdata;
        req.mask       = mask;
        req.we         = we;
        want_req.addr  = {addr[31:2], 2'b00};
        want_req.wdata = wdata;
        want_req.wstrb = we ? mask : 4'h0;
        stalls = 0;
        @(posedge clk);
        if (fetch_en) begin
            // the cache registers its refill request, so the fetch leads by one cycle
            // and both masters meet the arbiter while it is idle
            fetch_addr <= faddr;
            @(posedge clk);
        end
        data_sel <= 1'b1;
        data_req <= req;
        @(negedge clk);
        while (data_stall) begin
            if (mem_valid && we) begin
                check_req(name, want_req, mem_req);
            end
            stalls++;
            @(negedge clk);
        end
        rdata = data_rdata;
        @(posedge clk);
        data_sel <= 1'b0;
    endtask

    // ============================================================
    // stimulus table
    // ============================================================
    task automatic add_row(input string name, input op_e op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] mask,
                           input logic [31:0] exp);
        row_t r;
        r.name = name;
        r.op   = op;
        r.addr = addr;
        r.data = data;
        r.mask = mask;
        r.exp  = exp;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row("fetch_miss",   OP_FETCH, 32'h4000_0104, 32'h0,          4'h0, 32'd1);
        add_row("fetch_hit",    OP_FETCH, 32'h4000_0104, 32'h0,          4'h0, 32'd0);
        add_row("store_masked", OP_STORE, 32'h4000_0208, 32'hdead_beef,  4'h5, 32'd1);
        add_row("load_merged",  OP_LOAD,  32'h4000_0208, 32'h0,          4'h0, 32'd1);
        add_row("smc_fetch",    OP_FETCH, 32'h4000_030c, 32'h0,          4'h0, 32'd1);
        add_row("smc_store",    OP_STORE, 32'h4000_030c, 32'h1234_5678,  4'hf, 32'd1);
        add_row("smc_refetch",  OP_FETCH, 32'h4000_030c, 32'h0,          4'h0, 32'd1);
        // load address in addr, fetch address in data
        add_row("both_miss",    OP_BOTH,  32'h4000_0410, 32'h4000_0514,  4'h0, 32'd2);
        add_row("tmr_cmp_wr",   OP_TWR,   32'h1000_0004, 32'hffff_0000,  4'hf, 32'h0);
        add_row("tmr_cmp_rd",   OP_TRD,   32'h1000_0004, 32'h0,          4'h0, 32'hffff_0000);
        add_row("tmr_cnt_wr",   OP_TWR,   32'h1000_0000, 32'h0001_0000,  4'hf, 32'h0);
        add_row("tmr_cnt_rd",   OP_TCNT,  32'h1000_0000, 32'h0001_0000,  4'h0, 32'h0);
        add_row("irq_low",      OP_IRQ,   32'h0,         32'h0,          4'h0, 32'd0);
        add_row("tmr_cmp_low",  OP_TWR,   32'h1000_0004, 32'h0001_0000,  4'hf, 32'h0);
        add_row("irq_high",     OP_IRQ,   32'h0,         32'h0,          4'h0, 32'd1);
        add_row("tmr_cmp_max",  OP_TWR,   32'h1000_0004, 32'hffff_ffff,  4'hf, 32'h0);
        add_row("irq_cleared",  OP_IRQ,   32'h0,         32'h0,          4'h0, 32'd0);
        add_row("unmapped_rd",  OP_LOAD,  32'h2000_0010, 32'h0,          4'h0, 32'd0);
    endtask

    task automatic run_row(input row_t r);
        logic [31:0] got;
        logic [31:0] fgot;
        logic [31:0] want;
        int          stalls;
        int          base;
        base = i_tb_mem_model.xfer_cnt;
        case (r.op)
            OP_FETCH: begin
                @(posedge clk);
                fetch_addr <= r.addr;
                wait_fetch(r.name, r.exp == 32'd0, got);
                check_word(r.name, shadow[r.addr[11:2]], got);
            end
            OP_STORE: begin
                want = strobe_mask(r.mask);
                shadow[r.addr[11:2]] = (shadow[r.addr[11:2]] & ~want) | (r.data & want);
                run_data(r.name, r.addr, r.data, r.mask, 1'b1, 1'b0, 32'h0, got, stalls);
            end
            OP_LOAD: begin
                want = r.addr[MEM_SEL_BIT] ? shadow[r.addr[11:2]] : 32'h0;
                run_data(r.name, r.addr, 32'h0, 4'h0, 1'b0, 1'b0, 32'h0, got, stalls);
                check_word(r.name, want, got);
                if (!r.addr[MEM_SEL_BIT]) begin
                    check_count({r.name, " stalls"}, 0, stalls);
                end
            end
            OP_TWR, OP_TRD, OP_TCNT: begin
                run_data(r.name, r.addr, r.data, 4'hf, r.op == OP_TWR, 1'b0, 32'h0, got, stalls);
                check_count({r.name, " stalls"}, 0, stalls);
                if (r.op == OP_TRD) begin
                    check_word(r.name, r.exp, got);
                end
                // the count has moved on by at most the run time since it was loaded
                if (r.op == OP_TCNT && (got < r.data || got - r.data >= watchdog_cycles())) begin
                    report_failure($sformatf("ERR %s: expected %h or a little more, actual %h",
                        r.name, r.data, got));
                end
            end
            OP_IRQ: begin
                repeat (2) @(negedge clk);
                check_count(r.name, int'(r.exp), int'(timer_irq));
            end
            OP_BOTH: begin
                run_data(r.name, r.addr, 32'h0, 4'h0, 1'b0, 1'b1, r.data, got, stalls);
                wait_fetch(r.name, 1'b0, fgot);
                check_word({r.name, " load"}, shadow[r.addr[11:2]], got);
                check_word({r.name, " fetch"}, shadow[r.data[11:2]], fgot);
                check_word({r.name, " first"}, {r.addr[31:2], 2'b00},
                           i_tb_mem_model.log_addr[base[7:0]]);
                check_word({r.name, " second"}, {r.data[31:2], 2'b00},
                           i_tb_mem_model.log_addr[8'(base + 1)]);
            end
            default: begin
                report_failure("unknown operation in the row table");
            end
        endcase
        if (r.op inside {OP_FETCH, OP_LOAD, OP_STORE, OP_BOTH}) begin
            check_count({r.name, " transfers"}, int'(r.exp), i_tb_mem_model.xfer_cnt - base);
        end
    endtask

    // ============================================================
    // main sequence and watchdog
    // ============================================================
    initial begin
        rst_n      <= 1'b0;
        fetch_addr <= PARK_ADDR;
        data_sel   <= 1'b0;
        data_req   <= '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < 1024; i++) begin
            shadow[10'(i)] = i_tb_mem_model.mem[10'(i)];
        end
        // the parked address misses once out of reset
        @(negedge clk);
        while (fetch_wait) begin
            @(negedge clk);
        end
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        @(posedge clk);
        repeat (watchdog_cycles()) @(posedge clk);
        report_failure("watchdog expired because a stall or a fetch wait never ended");
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/soc_mem_pkg.sv
hw/machine_timer.sv
hw/instr_cache.sv
hw/mem_ctrl.sv
hw/mem_subsystem.sv
tb/tb_mem_model.sv
tb/tb_mem_subsystem.sv
